/* common/rvv_config.svh */
// queue depths must stay powers of two, the pointers wrap by truncation
`ifndef RVV_CONFIG_SVH
`define RVV_CONFIG_SVH

// command queue entries
`define CQ_DEPTH 4

// uop queue entries
`define UQ_DEPTH 16

// push lanes from decoder into the uop queue
`define NUM_DE_UOP 4

// largest split, one uop per register of a group of 8
`define MAX_UOP 8

`endif

/* common/rvv_pkg.sv */
// types and field positions assume RV32 OP-V encodings; scalar operands are not modelled
`default_nettype none

package rvv_pkg;

  // raw words
  typedef logic [31:0] inst_t;
  typedef logic [1:0]  lmul_t;
  // group code on top of the instruction
  typedef logic [33:0] cmd_t;
  typedef logic [2:0]  uop_idx_t;
  // uop index on top of the rewritten instruction
  typedef logic [34:0] uop_t;
  typedef logic [3:0]  uop_cnt_t;

  localparam int INST_W = 32;
  localparam int REG_W  = 5;

  // instruction field positions
  localparam int OPC_LSB = 0;
  localparam int VD_LSB  = 7;
  localparam int F3_LSB  = 12;
  localparam int VS1_LSB = 15;
  localparam int VS2_LSB = 20;
  localparam int F6_LSB  = 26;

  // major opcode for all vector arithmetic
  localparam logic [6:0] OPC_OPV = 7'b1010111;

  // vmv<nr>r.v is OPIVI with nr-1 in the simm5 field
  localparam logic [5:0] F6_VMVNR = 6'b100111;
  localparam logic [2:0] F3_VMVNR = 3'b011;

  // vmv.v.v, OPIVV
  localparam logic [5:0] F6_VMV = 6'b010111;
  localparam logic [2:0] F3_VMV = 3'b000;

endpackage

`default_nettype wire

/* common/cq_de_if.sv */
// cmd1 only holds a real command while both empty and one_left are low
`timescale 1ns/1ps
`default_nettype none

interface cq_de_if
  import rvv_pkg::*;
();

  // two oldest entries
  cmd_t cmd0;
  cmd_t cmd1;
  // occupancy levels
  logic empty;
  logic one_left;
  // pop1 only together with pop0
  logic pop0;
  logic pop1;

  modport source (output cmd0, cmd1, empty, one_left, input pop0, pop1);
  modport decoder (input cmd0, cmd1, empty, one_left, output pop0, pop1);

endinterface

`default_nettype wire

/* common/de_uq_if.sv */
// push lanes are contiguous from lane 0 and never exceed the free slots
`timescale 1ns/1ps
`default_nettype none

`include "rvv_config.svh"

interface de_uq_if
  import rvv_pkg::*;
();

  // push lanes, lane 0 oldest
  logic [`NUM_DE_UOP-1:0] push;
  uop_t [`NUM_DE_UOP-1:0] data;

  // fullness levels from the uop queue
  logic full;
  // exactly one free slot
  logic left1;
  logic left2;
  logic left3;

  modport source (output push, data, input full, left1, left2, left3);
  modport sink (input push, data, output full, left1, left2, left3);

endinterface

`default_nettype wire

/* source/rvv_cmd_queue.sv */
// push while full is dropped silently; depth must be a power of two of at least 2
`timescale 1ns/1ps
`default_nettype none

`include "rvv_config.svh"

module rvv_cmd_queue
  import rvv_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     push,
  input  cmd_t     data,
  output logic     full,
  cq_de_if.source  cq
);

  localparam int AW = $clog2(`CQ_DEPTH);
  localparam int CW = $clog2(`CQ_DEPTH + 1);

  cmd_t          mem [`CQ_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          push_ok;
  logic [1:0]    npop;

  assign push_ok = push && !full;
  assign npop    = {1'b0, cq.pop0} + {1'b0, cq.pop1};

  // levels
  assign full        = count == CW'(`CQ_DEPTH);
  assign cq.empty    = count == '0;
  assign cq.one_left = count == CW'(1);

  // two oldest entries, pointer wraps
  assign cq.cmd0 = mem[rd_ptr];
  assign cq.cmd1 = mem[rd_ptr + 1'b1];

  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      wr_ptr <= wr_ptr + AW'(push_ok);
      rd_ptr <= rd_ptr + AW'(npop);
      count  <= count + CW'(push_ok) - CW'(npop);
    end
  end

  // decoder pops only what it can see
  a_pop_not_empty: assert property (@(posedge clk) disable iff (reset)
    cq.pop0 |-> !cq.empty);
  a_pop1_pair: assert property (@(posedge clk) disable iff (reset)
    cq.pop1 |-> cq.pop0 && !cq.one_left);

endmodule

`default_nettype wire

/* source/rvv_uop_queue.sv */
// pop while empty is ignored; depth must be a power of two above the lane count
`timescale 1ns/1ps
`default_nettype none

`include "rvv_config.svh"

module rvv_uop_queue
  import rvv_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  de_uq_if.sink   uq,
  input  logic    pop,
  output uop_t    data,
  output logic    empty
);

  localparam int AW = $clog2(`UQ_DEPTH);
  localparam int CW = $clog2(`UQ_DEPTH + 1);

  uop_t          mem [`UQ_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic [CW-1:0] npush;
  logic [CW-1:0] free;
  logic          pop_ok;

  assign npush  = CW'($countones(uq.push));
  assign free   = CW'(`UQ_DEPTH) - count;
  assign pop_ok = pop && !empty;

  // fullness levels for the decoder
  assign uq.full  = count == CW'(`UQ_DEPTH);
  assign uq.left1 = count == CW'(`UQ_DEPTH - 1);
  assign uq.left2 = count == CW'(`UQ_DEPTH - 2);
  assign uq.left3 = count == CW'(`UQ_DEPTH - 3);

  assign empty = count == '0;
  // oldest uop
  assign data  = mem[rd_ptr];

  // lane k lands k slots after the write pointer
  always_ff @(posedge clk) begin
    for (int k = 0; k < `NUM_DE_UOP; k++) begin
      if (uq.push[k]) begin
        mem[wr_ptr + AW'(k)] <= uq.data[k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      wr_ptr <= wr_ptr + AW'(npush);
      rd_ptr <= rd_ptr + AW'(pop_ok);
      count  <= count + npush - CW'(pop_ok);
    end
  end

  // lanes fill from 0 upward with no gaps
  a_push_contig: assert property (@(posedge clk) disable iff (reset)
    ((uq.push + 1'b1) & uq.push) == '0);
  // decoder honours the levels
  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    npush <= free);

endmodule

`default_nettype wire

/* rvv_decode/rvv_decode_unit.sv */
// combinational only; vs1 advances for every OP-V form, scalar and immediate forms included
`timescale 1ns/1ps
`default_nettype none

`include "rvv_config.svh"

module rvv_decode_unit
  import rvv_pkg::*;
(
  input  logic                   valid,
  input  cmd_t                   cmd,
  input  uop_idx_t               start_idx,
  output logic [`NUM_DE_UOP-1:0] uop_valid,
  output uop_t [`NUM_DE_UOP-1:0] uops,
  output uop_cnt_t               count,
  output logic                   legal
);

  inst_t            inst;
  lmul_t            lmul;
  logic             is_opv;
  logic             is_wmove;
  logic [REG_W-1:0] nr_field;
  uop_cnt_t         nr_cnt;
  logic             nr_ok;

  // split the command word
  assign inst = cmd[INST_W-1:0];
  assign lmul = cmd[$bits(cmd_t)-1 -: $bits(lmul_t)];

  // classification
  assign is_opv   = inst[OPC_LSB +: 7] == OPC_OPV;
  assign is_wmove = is_opv && (inst[F6_LSB +: 6] == F6_VMVNR) &&
                    (inst[F3_LSB +: 3] == F3_VMVNR);

  // nr-1 sits in simm5, only 1/2/4/8 allowed
  assign nr_field = inst[VS1_LSB +: REG_W];
  assign nr_cnt   = uop_cnt_t'(nr_field[2:0]) + uop_cnt_t'(1);
  assign nr_ok    = (nr_field < REG_W'(`MAX_UOP)) && ((nr_cnt & (nr_cnt - 1'b1)) == '0);

  assign legal = valid && is_opv && (!is_wmove || nr_ok);

  // total uops, zero for dropped commands
  always_comb begin
    if (!legal) begin
      count = '0;
    end else if (is_wmove) begin
      count = nr_cnt;
    end else begin
      count = uop_cnt_t'(1) << lmul;
    end
  end

  // one uop per lane, index start_idx+k
  always_comb begin
    uop_cnt_t idx_ext;
    uop_idx_t idx;
    inst_t    word;
    for (int k = 0; k < `NUM_DE_UOP; k++) begin
      idx_ext = uop_cnt_t'(start_idx) + uop_cnt_t'(k);
      idx     = idx_ext[2:0];
      word    = inst;
      // destination always steps with the index
      word[VD_LSB +: REG_W] = inst[VD_LSB +: REG_W] + REG_W'(idx);
      if (is_wmove) begin
        // rewrite to vmv.v.v, source comes from vs2
        word[F6_LSB +: 6]      = F6_VMV;
        word[F3_LSB +: 3]      = F3_VMV;
        word[VS1_LSB +: REG_W] = inst[VS2_LSB +: REG_W] + REG_W'(idx);
        word[VS2_LSB +: REG_W] = '0;
      end else begin
        word[VS1_LSB +: REG_W] = inst[VS1_LSB +: REG_W] + REG_W'(idx);
        word[VS2_LSB +: REG_W] = inst[VS2_LSB +: REG_W] + REG_W'(idx);
      end
      // lanes past the count stay empty
      uop_valid[k] = legal && (idx_ext < count);
      uops[k]      = {idx, word};
    end
  end

endmodule

`default_nettype wire

/* rvv_decode/rvv_decode_ctrl.sv */
// unit1 is appended only when it finishes in the same cycle; no partial second command
`timescale 1ns/1ps
`default_nettype none

`include "rvv_config.svh"

module rvv_decode_ctrl
  import rvv_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   valid0,
  input  logic                   valid1,
  input  logic [`NUM_DE_UOP-1:0] u0_valid,
  input  uop_t [`NUM_DE_UOP-1:0] u0_uops,
  input  uop_cnt_t               u0_count,
  input  logic                   u0_legal,
  input  logic [`NUM_DE_UOP-1:0] u1_valid,
  input  uop_t [`NUM_DE_UOP-1:0] u1_uops,
  input  uop_cnt_t               u1_count,
  input  logic                   u1_legal,
  output uop_idx_t               remain_idx,
  cq_de_if.decoder               cq,
  de_uq_if.source                uq
);

  localparam int LW = $clog2(`NUM_DE_UOP);

  uop_cnt_t free;
  uop_cnt_t n0;
  uop_cnt_t n1;
  uop_cnt_t p0;
  uop_cnt_t room;
  logic     done0;
  logic     take1;

  // free slots from the queue levels
  always_comb begin
    if (uq.full) begin
      free = uop_cnt_t'(0);
    end else if (uq.left1) begin
      free = uop_cnt_t'(1);
    end else if (uq.left2) begin
      free = uop_cnt_t'(2);
    end else if (uq.left3) begin
      free = uop_cnt_t'(3);
    end else begin
      free = uop_cnt_t'(`NUM_DE_UOP);
    end
  end

  // valid lanes are contiguous, so popcount is the lane count
  assign n0 = uop_cnt_t'($countones(u0_valid));
  assign n1 = uop_cnt_t'($countones(u1_valid));

  // head uops that fit this cycle
  assign p0   = (n0 < free) ? n0 : free;
  assign room = free - p0;

  // head finished, illegal heads finish at once
  assign done0 = valid0 && (!u0_legal || (uop_cnt_t'(remain_idx) + p0 == u0_count));

  // second command must complete in the leftover room
  // illegal one has zero count and is dropped along
  assign take1 = done0 && valid1 && (n1 == u1_count) && (n1 <= room);

  assign cq.pop0 = done0;
  assign cq.pop1 = take1;

  // lane packing, head first then unit1
  always_comb begin
    uop_cnt_t rel;
    for (int k = 0; k < `NUM_DE_UOP; k++) begin
      rel = uop_cnt_t'(k) - p0;
      if (uop_cnt_t'(k) < p0) begin
        uq.push[k] = u0_valid[k];
        uq.data[k] = u0_uops[k];
      end else begin
        // only legal unit1 has valid lanes
        uq.push[k] = take1 && u1_legal && u1_valid[rel[LW-1:0]];
        uq.data[k] = u1_uops[rel[LW-1:0]];
      end
    end
  end

  // resume point of the head
  always_ff @(posedge clk) begin
    if (reset) begin
      remain_idx <= '0;
    end else if (done0) begin
      remain_idx <= '0;
    end else if (valid0) begin
      remain_idx <= remain_idx + p0[2:0];
    end
  end

  // pushes never exceed what the uop queue reports as free
  a_push_le_free: assert property (@(posedge clk) disable iff (reset)
    !(uq.full && uq.push[0]) && !(uq.left1 && uq.push[1]) &&
    !(uq.left2 && uq.push[2]) && !(uq.left3 && uq.push[3]));

endmodule

`default_nettype wire

/* rvv_decode/rvv_decode.sv */
// unit1 always starts at index 0, so only the head command can be split over cycles
`timescale 1ns/1ps
`default_nettype none

`include "rvv_config.svh"

module rvv_decode
  import rvv_pkg::*;
(
  input  logic clk,
  input  logic reset,
  cq_de_if.decoder cq,
  de_uq_if.source  uq
);

  logic valid0;
  logic valid1;

  // unit0 outputs
  logic [`NUM_DE_UOP-1:0] u0_valid;
  uop_t [`NUM_DE_UOP-1:0] u0_uops;
  uop_cnt_t               u0_count;
  logic                   u0_legal;

  // unit1 outputs
  logic [`NUM_DE_UOP-1:0] u1_valid;
  uop_t [`NUM_DE_UOP-1:0] u1_uops;
  uop_cnt_t               u1_count;
  logic                   u1_legal;

  // where the head command resumes
  uop_idx_t remain_idx;

  // entry valid bits from the queue levels
  assign valid0 = !cq.empty;
  assign valid1 = !(cq.empty | cq.one_left);

  // head command, resumes at remain_idx
  rvv_decode_unit u_unit0 (
    .valid     (valid0),
    .cmd       (cq.cmd0),
    .start_idx (remain_idx),
    .uop_valid (u0_valid),
    .uops      (u0_uops),
    .count     (u0_count),
    .legal     (u0_legal)
  );

  // second command, fresh start
  rvv_decode_unit u_unit1 (
    .valid     (valid1),
    .cmd       (cq.cmd1),
    .start_idx (uop_idx_t'(0)),
    .uop_valid (u1_valid),
    .uops      (u1_uops),
    .count     (u1_count),
    .legal     (u1_legal)
  );

  rvv_decode_ctrl u_ctrl (
    .clk        (clk),
    .reset      (reset),
    .valid0     (valid0),
    .valid1     (valid1),
    .u0_valid   (u0_valid),
    .u0_uops    (u0_uops),
    .u0_count   (u0_count),
    .u0_legal   (u0_legal),
    .u1_valid   (u1_valid),
    .u1_uops    (u1_uops),
    .u1_count   (u1_count),
    .u1_legal   (u1_legal),
    .remain_idx (remain_idx),
    .cq         (cq),
    .uq         (uq)
  );

endmodule

`default_nettype wire

/* source/rvv_decode_top.sv */
// uop_data is only meaningful while uop_empty is low; first uop arrives two edges after push at best
`timescale 1ns/1ps
`default_nettype none

module rvv_decode_top
  import rvv_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  // command side
  input  logic  cmd_push,
  input  lmul_t cmd_lmul,
  input  inst_t cmd_inst,
  output logic  cmd_full,
  // uop side
  input  logic  uop_pop,
  output uop_t  uop_data,
  output logic  uop_empty
);

  cq_de_if cq ();
  de_uq_if uq ();

  // group code travels on top of the instruction
  rvv_cmd_queue u_cmd_queue (
    .clk   (clk),
    .reset (reset),
    .push  (cmd_push),
    .data  ({cmd_lmul, cmd_inst}),
    .full  (cmd_full),
    .cq    (cq)
  );

  rvv_decode u_decode (
    .clk   (clk),
    .reset (reset),
    .cq    (cq),
    .uq    (uq)
  );

  rvv_uop_queue u_uop_queue (
    .clk   (clk),
    .reset (reset),
    .uq    (uq),
    .pop   (uop_pop),
    .data  (uop_data),
    .empty (uop_empty)
  );

endmodule

`default_nettype wire

/* tb/tb_rvv_decode_top.sv */
// directed tests only; expected uops come from a model of the split rule, drained in order
`timescale 1ns/1ps
`default_nettype none

module tb_rvv_decode_top
  import rvv_pkg::*;
();

  // cycles any single wait may take
  localparam int TIMEOUT = 200;

  logic  clk;
  logic  reset;
  logic  cmd_push;
  lmul_t cmd_lmul;
  inst_t cmd_inst;
  logic  cmd_full;
  logic  uop_pop;
  uop_t  uop_data;
  logic  uop_empty;

  uop_t   exp_q[$];
  int     errors;
  int     checks;
  integer seed;

  rvv_decode_top i_dut (
    .clk       (clk),
    .reset     (reset),
    .cmd_push  (cmd_push),
    .cmd_lmul  (cmd_lmul),
    .cmd_inst  (cmd_inst),
    .cmd_full  (cmd_full),
    .uop_pop   (uop_pop),
    .uop_data  (uop_data),
    .uop_empty (uop_empty)
  );

  // 40 ns period
  always #20 clk = ~clk;

  // counts, verdict, stop
  task automatic end_run();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    $display("ERROR at %0t: timed out after %0d cycles waiting for %s", $time, TIMEOUT, what);
    errors++;
    end_run();
  endtask

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string msg);
    checks++;
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
      errors++;
    end
  endtask

  // OP-V arithmetic word, unmasked
  function automatic inst_t opv_arith(input logic [5:0] f6, input logic [4:0] vs2,
                                      input logic [4:0] vs1, input logic [2:0] f3,
                                      input logic [4:0] vd);
    return {f6, 1'b1, vs2, vs1, f3, vd, 7'b1010111};
  endfunction

  // vmv<nr>r.v, nr-1 goes into simm5
  function automatic inst_t wmove(input int nr, input logic [4:0] vs2, input logic [4:0] vd);
    logic [4:0] simm;
    simm = 5'(nr - 1);
    return {6'b100111, 1'b1, vs2, simm, 3'b011, vd, 7'b1010111};
  endfunction

  // reference split, appends the uops one command produces
  task automatic add_expected(input lmul_t lmul, input inst_t inst);
    int         nr;
    logic [2:0] i3;
    inst_t      w;
    nr = int'(inst[19:15]) + 1;
    if (inst[6:0] != 7'b1010111) begin
      // not vector arithmetic, dropped
    end else if (inst[31:26] == 6'b100111 && inst[14:12] == 3'b011) begin
      if (nr == 1 || nr == 2 || nr == 4 || nr == 8) begin
        for (int i = 0; i < nr; i++) begin
          i3 = 3'(i);
          // becomes vmv.v.v vd+i, v(src+i)
          w = {6'b010111, inst[25], 5'd0, 5'(inst[24:20] + i), 3'b000,
               5'(inst[11:7] + i), inst[6:0]};
          exp_q.push_back({i3, w});
        end
      end
    end else begin
      for (int i = 0; i < (1 << lmul); i++) begin
        i3 = 3'(i);
        w = {inst[31:25], 5'(inst[24:20] + i), 5'(inst[19:15] + i), inst[14:12],
             5'(inst[11:7] + i), inst[6:0]};
        exp_q.push_back({i3, w});
      end
    end
  endtask

  // called and returns 2 ns after a rising edge
  task automatic push_cmd(input lmul_t lmul, input inst_t inst);
    int waited;
    waited = 0;
    while (cmd_full) begin
      @(posedge clk);
      #2;
      waited++;
      if (waited > TIMEOUT) report_timeout("command queue space");
    end
    cmd_push = 1'b1;
    cmd_lmul = lmul;
    cmd_inst = inst;
    @(posedge clk);
    #2;
    cmd_push = 1'b0;
    add_expected(lmul, inst);
  endtask

  // pop until every expected uop has been seen
  task automatic drain_uops(input string tag);
    int   waited;
    uop_t exp;
    while (exp_q.size() > 0) begin
      waited = 0;
      while (uop_empty) begin
        @(posedge clk);
        #2;
        waited++;
        if (waited > TIMEOUT) report_timeout({"a uop in ", tag});
      end
      exp = exp_q.pop_front();
      check_value(64'(uop_data), 64'(exp), tag);
      uop_pop = 1'b1;
      @(posedge clk);
      #2;
      uop_pop = 1'b0;
    end
  endtask

  // nothing may show up once the list is empty
  task automatic check_idle(input int cycles);
    repeat (cycles) begin
      check_value(64'(uop_empty), 64'd1, "uop queue stays empty");
      @(posedge clk);
      #2;
    end
  endtask

  task automatic test_reset_single();
    check_value(64'(uop_empty), 64'd1, "uop_empty after reset");
    check_value(64'(cmd_full), 64'd0, "cmd_full after reset");
    // vadd.vv v3, v9, v5 gives one uop equal to itself
    push_cmd(2'd0, opv_arith(6'b000000, 5'd9, 5'd5, 3'b000, 5'd3));
    drain_uops("group of 1");
    // exactly one uop
    check_idle(4);
  endtask

  task automatic test_group8();
    logic [31:0] r;
    logic [4:0]  vd;
    logic [4:0]  vs1;
    logic [4:0]  vs2;
    r   = $random(seed);
    vd  = r[4:0];
    vs1 = r[12:8];
    vs2 = r[20:16];
    // vmul.vv, fields wrap past v31
    push_cmd(2'd3, opv_arith(6'b100101, vs2, vs1, 3'b010, vd));
    drain_uops("group of 8");
  endtask

  task automatic test_whole_moves();
    push_cmd(2'd0, wmove(2, 5'd4, 5'd2));
    push_cmd(2'd1, wmove(4, 5'd12, 5'd8));
    push_cmd(2'd3, wmove(8, 5'd24, 5'd16));
    drain_uops("whole-register moves");
  endtask

  task automatic test_illegal();
    // long head, the dropped word behind it leaves in the same cycle
    push_cmd(2'd3, opv_arith(6'b000010, 5'd6, 5'd10, 3'b000, 5'd20));
    // integer add, major opcode OP
    push_cmd(2'd0, 32'h00b50533);
    push_cmd(2'd0, opv_arith(6'b000000, 5'd1, 5'd2, 3'b100, 5'd3));
    push_cmd(2'd2, wmove(3, 5'd4, 5'd0));
    push_cmd(2'd2, opv_arith(6'b001001, 5'd16, 5'd20, 3'b000, 5'd24));
    drain_uops("dropped commands");
  endtask

  task automatic test_backpressure();
    // 8+4+8+4+1+1 uops, more than the uop queue holds
    push_cmd(2'd3, opv_arith(6'b000000, 5'd8, 5'd16, 3'b000, 5'd0));
    push_cmd(2'd2, opv_arith(6'b000010, 5'd4, 5'd12, 3'b000, 5'd20));
    push_cmd(2'd3, wmove(8, 5'd8, 5'd24));
    push_cmd(2'd2, opv_arith(6'b100101, 5'd28, 5'd1, 3'b010, 5'd4));
    push_cmd(2'd0, opv_arith(6'b000000, 5'd7, 5'd6, 3'b000, 5'd5));
    push_cmd(2'd0, opv_arith(6'b001001, 5'd3, 5'd2, 3'b000, 5'd1));
    drain_uops("back-pressure");
    // long head lets short commands pile up and pair in one cycle
    push_cmd(2'd3, opv_arith(6'b000000, 5'd0, 5'd8, 3'b000, 5'd16));
    push_cmd(2'd0, opv_arith(6'b000000, 5'd11, 5'd12, 3'b000, 5'd13));
    push_cmd(2'd1, opv_arith(6'b000010, 5'd14, 5'd16, 3'b000, 5'd18));
    push_cmd(2'd0, wmove(1, 5'd30, 5'd31));
    push_cmd(2'd0, opv_arith(6'b001010, 5'd21, 5'd22, 3'b000, 5'd23));
    drain_uops("short commands");
  endtask

  initial begin
    seed     = 32'h9e41bf3e;
    errors   = 0;
    checks   = 0;
    clk      = 1'b0;
    reset    = 1'b1;
    cmd_push = 1'b0;
    cmd_lmul = '0;
    cmd_inst = '0;
    uop_pop  = 1'b0;
    repeat (10) @(posedge clk);
    #2;
    reset = 1'b0;

    test_reset_single();
    test_group8();
    test_whole_moves();
    test_illegal();
    test_backpressure();
    check_idle(20);
    end_run();
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+common
common/rvv_pkg.sv
common/cq_de_if.sv
common/de_uq_if.sv
source/rvv_cmd_queue.sv
source/rvv_uop_queue.sv
rvv_decode/rvv_decode_unit.sv
rvv_decode/rvv_decode_ctrl.sv
rvv_decode/rvv_decode.sv
source/rvv_decode_top.sv
tb/tb_rvv_decode_top.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_rvv_decode_top -o sim
./obj_dir/sim | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
  exit 0
else
  echo "simulation did not pass, see sim.log"
  exit 1
fi
